/* Bender.yml */
package:
  name: rv32i_fetch_front

sources:
  # package first, then the stages, then the top level
  - rtl/fetch_pkg.sv
  - rtl/fetch_stage.sv
  - rtl/instr_queue.sv
  - rtl/decode_stage.sv
  - rtl/fetch_top.sv

  # testbench, top module tb_fetch_top
  - target: simulation
    files:
      - tb/tb_fetch_top.sv

/* all.f */
rtl/fetch_pkg.sv
rtl/fetch_stage.sv
rtl/instr_queue.sv
rtl/decode_stage.sv
rtl/fetch_top.sv
tb/tb_fetch_top.sv

/* rtl/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  stall_i,       // back-pressure from later stages
    input  logic                  q_valid_i,
    input  fetch_pkg::fetch_pkt_t q_pkt_i,
    output logic                  q_pop_o,
    output logic                  redirect_o,    // jal taken this cycle
    output fetch_pkg::word_t      redirect_pc_o,
    output logic                  dec_valid_o,
    output fetch_pkg::word_t      dec_pc_o,
    output fetch_pkg::word_t      dec_ir_o,
    output logic [4:0]            dec_rd_o,
    output fetch_pkg::word_t      dec_imm_o
);

    fetch_pkg::word_t ir_w;
    logic [6:0]       opc_w;
    logic             is_jal;
    fetch_pkg::word_t imm_w;
    fetch_pkg::word_t dec_pc_q;
    fetch_pkg::word_t dec_ir_q;
    logic [4:0]       dec_rd_q;
    fetch_pkg::word_t dec_imm_q;
    logic             dec_valid_q;

    assign ir_w   = q_pkt_i.ir;
    assign opc_w  = fetch_pkg::opcode(ir_w);
    assign is_jal = (opc_w == fetch_pkg::OPC_JAL);

    // take the head whenever downstream lets us
    assign q_pop_o = q_valid_i & ~stall_i;

    // immediate by format
    always_comb begin
        case (opc_w)
            fetch_pkg::OPC_OP_IMM: imm_w = fetch_pkg::imm_i(ir_w);
            fetch_pkg::OPC_JAL:    imm_w = fetch_pkg::imm_j(ir_w);
            default:               imm_w = '0; // no immediate decoded
        endcase
    end

    // jal resolves here in the same cycle as the pop
    assign redirect_o    = q_pop_o & is_jal;
    assign redirect_pc_o = q_pkt_i.pc + fetch_pkg::imm_j(ir_w);

    always_ff @(posedge clk_i) begin
        if (reset_i)
            dec_valid_q <= 1'b0;
        else
            dec_valid_q <= q_pop_o; // one cycle per popped packet
    end

    // payload only moves on a pop
    always_ff @(posedge clk_i) begin
        if (q_pop_o) begin
            dec_pc_q  <= q_pkt_i.pc;
            dec_ir_q  <= ir_w;
            dec_rd_q  <= fetch_pkg::rd_field(ir_w);
            dec_imm_q <= imm_w;
        end
    end

    assign dec_valid_o = dec_valid_q;
    assign dec_pc_o    = dec_pc_q;
    assign dec_ir_o    = dec_ir_q;
    assign dec_rd_o    = dec_rd_q;
    assign dec_imm_o   = dec_imm_q;

    // a jal redirect leaves no wrong-path entry behind in the queue
    redirect_flush_a: assert property (
        @(posedge clk_i) disable iff (reset_i)
        redirect_o |=> !q_valid_i
    ) else $error("queue still holds entries after jal redirect");

endmodule

/* rtl/fetch_pkg.sv */
package fetch_pkg;

    // basic datapath word
    typedef logic [31:0] word_t;

    // one fetched instruction with its address
    // pc sits in the upper half, ir in the lower
    typedef struct packed {
        word_t pc;
        word_t ir;
    } fetch_pkt_t;

    // queue sizing
    localparam int unsigned QUEUE_DEPTH = 4;             // entries, also initial credits
    localparam int unsigned CREDIT_W    = 3;             // counts 0..QUEUE_DEPTH
    localparam int unsigned IDX_W       = $clog2(QUEUE_DEPTH); // storage index bits

    // full credit count at counter width
    localparam logic [CREDIT_W-1:0] DEPTH_CNT = CREDIT_W'(QUEUE_DEPTH);

    // first address fetched after reset
    localparam word_t RESET_PC = 32'h0000_0000;

    // rv32i major opcodes used by the front end
    localparam logic [6:0] OPC_JAL    = 7'b110_1111;
    localparam logic [6:0] OPC_OP_IMM = 7'b001_0011; // addi and friends

    // i-format immediate, ir[31:20] sign extended
    function automatic word_t imm_i(input word_t ir);
        word_t imm;
        imm = {{20{ir[31]}}, ir[31:20]};
        return imm;
    endfunction

    // j-format immediate
    // scrambled bits 20|10:1|11|19:12, lsb always zero
    function automatic word_t imm_j(input word_t ir);
        word_t imm;
        imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
        return imm;
    endfunction

    // rd field sits at the same spot in every format that has one
    function automatic logic [4:0] rd_field(input word_t ir);
        logic [4:0] rd;
        rd = ir[11:7];
        return rd;
    endfunction

    // major opcode, low seven bits
    function automatic logic [6:0] opcode(input word_t ir);
        logic [6:0] opc;
        opc = ir[6:0];
        return opc;
    endfunction

endpackage

/* rtl/fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  halt_i,          // hold pc and issue no request
    input  fetch_pkg::word_t      imem_data_i,     // data for last cycle's address
    input  logic                  redirect_i,      // jal accepted in decode
    input  fetch_pkg::word_t      redirect_pc_i,   // jal target
    input  logic                  credit_return_i, // one queue slot freed
    output fetch_pkg::word_t      imem_addr_o,     // address requested this cycle
    output logic                  push_valid_o,
    output fetch_pkg::fetch_pkt_t push_pkt_o
);

    fetch_pkg::word_t pc_q;  // address of latest request or the one still owed
    fetch_pkg::word_t pc_w;
    logic             pend_q; // pc_q not requested yet
    logic             pend_w;
    logic             req_q;  // request went out last cycle, data arrives now
    logic             req_w;

    logic [fetch_pkg::CREDIT_W-1:0] credits_q; // free slots incl. in-flight
    logic [fetch_pkg::CREDIT_W-1:0] credits_w;
    logic [fetch_pkg::CREDIT_W-1:0] req_cnt;
    logic [fetch_pkg::CREDIT_W-1:0] ret_cnt;

    // next pc by priority reset > redirect > halt > no credit > advance
    always_comb begin
        priority if (reset_i) begin
            pc_w  = fetch_pkg::RESET_PC;
            req_w = 1'b0;
        end else if (redirect_i) begin
            pc_w  = redirect_pc_i; // queue refills, so credit is guaranteed
            req_w = ~halt_i;
        end else if (halt_i) begin
            pc_w  = pc_q;
            req_w = 1'b0;
        end else if (credits_q == '0) begin
            pc_w  = pc_q;          // wait while queue and in-flight slots are full
            req_w = 1'b0;
        end else begin
            // a target that was never requested goes out as is
            pc_w  = pend_q ? pc_q : pc_q + 32'd4;
            req_w = 1'b1;
        end
    end

    // memory always sees the next pc
    assign imem_addr_o = pc_w;

    // owed flag survives halt and is set when redirect had no request behind it
    always_comb begin
        if (req_w)
            pend_w = 1'b0;
        else if (redirect_i)
            pend_w = 1'b1;
        else
            pend_w = pend_q;
    end

    assign req_cnt = {{(fetch_pkg::CREDIT_W-1){1'b0}}, req_w};
    assign ret_cnt = {{(fetch_pkg::CREDIT_W-1){1'b0}}, credit_return_i};

    // credit taken at request time rather than at push
    always_comb begin
        if (redirect_i)
            credits_w = fetch_pkg::DEPTH_CNT - req_cnt; // queue flushed
        else
            credits_w = credits_q - req_cnt + ret_cnt;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q      <= fetch_pkg::RESET_PC;
            pend_q    <= 1'b1;  // reset pc still owed
            req_q     <= 1'b0;
            credits_q <= fetch_pkg::DEPTH_CNT;
        end else begin
            pc_q      <= pc_w;
            pend_q    <= pend_w;
            req_q     <= req_w;
            credits_q <= credits_w;
        end
    end

    // response lands one cycle after request and is dropped if a jump hit meanwhile
    assign push_valid_o  = req_q & ~redirect_i;
    assign push_pkt_o.pc = pc_q;
    assign push_pkt_o.ir = imem_data_i;

    // underflow wraps past DEPTH_CNT, so one bound covers both directions
    credit_range_a: assert property (
        @(posedge clk_i) disable iff (reset_i)
        credits_q <= fetch_pkg::DEPTH_CNT
    ) else $error("fetch credit counter out of range: %0d", credits_q);

endmodule

/* rtl/fetch_top.sv */
`timescale 1ns/100ps

module fetch_top (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             halt_i,      // freeze fetch
    input  logic             stall_i,     // freeze decode
    input  fetch_pkg::word_t imem_data_i, // synchronous read data
    output fetch_pkg::word_t imem_addr_o,
    output logic             dec_valid_o,
    output fetch_pkg::word_t dec_pc_o,
    output fetch_pkg::word_t dec_ir_o,
    output logic [4:0]       dec_rd_o,
    output fetch_pkg::word_t dec_imm_o
);

    logic                  push_valid;
    fetch_pkg::fetch_pkt_t push_pkt;
    logic                  credit_return;
    logic                  q_valid;
    fetch_pkg::fetch_pkt_t q_pkt;
    logic                  q_pop;
    logic                  redirect;     // also the queue flush
    fetch_pkg::word_t      redirect_pc;

    fetch_stage u_fetch (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .halt_i          (halt_i),
        .imem_data_i     (imem_data_i),
        .redirect_i      (redirect),
        .redirect_pc_i   (redirect_pc),
        .credit_return_i (credit_return),
        .imem_addr_o     (imem_addr_o),
        .push_valid_o    (push_valid),
        .push_pkt_o      (push_pkt)
    );

    instr_queue u_queue (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .flush_i         (redirect),
        .push_valid_i    (push_valid),
        .push_pkt_i      (push_pkt),
        .pop_i           (q_pop),
        .q_valid_o       (q_valid),
        .q_pkt_o         (q_pkt),
        .credit_return_o (credit_return)
    );

    decode_stage u_decode (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .stall_i       (stall_i),
        .q_valid_i     (q_valid),
        .q_pkt_i       (q_pkt),
        .q_pop_o       (q_pop),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .dec_valid_o   (dec_valid_o),
        .dec_pc_o      (dec_pc_o),
        .dec_ir_o      (dec_ir_o),
        .dec_rd_o      (dec_rd_o),
        .dec_imm_o     (dec_imm_o)
    );

endmodule

/* rtl/instr_queue.sv */
`timescale 1ns/100ps

module instr_queue (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  flush_i,         // jal redirect drops everything
    input  logic                  push_valid_i,
    input  fetch_pkg::fetch_pkt_t push_pkt_i,
    input  logic                  pop_i,
    output logic                  q_valid_o,       // head entry present
    output fetch_pkg::fetch_pkt_t q_pkt_o,         // head entry
    output logic                  credit_return_o  // one pulse per pop
);

    fetch_pkg::fetch_pkt_t mem_q [fetch_pkg::QUEUE_DEPTH]; // packet storage

    logic [fetch_pkg::CREDIT_W-1:0] wr_ptr_q;
    logic [fetch_pkg::CREDIT_W-1:0] rd_ptr_q;
    logic [fetch_pkg::CREDIT_W-1:0] count_q;  // occupancy
    logic                           push_ok;
    logic                           pop_ok;

    // circular increment for any depth
    function automatic logic [fetch_pkg::CREDIT_W-1:0] ptr_inc(
        input logic [fetch_pkg::CREDIT_W-1:0] ptr
    );
        logic [fetch_pkg::CREDIT_W-1:0] nxt;
        if (ptr == fetch_pkg::DEPTH_CNT - 1'b1)
            nxt = '0;
        else
            nxt = ptr + 1'b1;
        return nxt;
    endfunction

    // flush wins over both sides
    assign push_ok = push_valid_i & ~flush_i;
    assign pop_ok  = pop_i & ~flush_i;

    // packet written at the tail
    always_ff @(posedge clk_i) begin
        if (push_ok)
            mem_q[wr_ptr_q[fetch_pkg::IDX_W-1:0]] <= push_pkt_i;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok)
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (pop_ok)
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            case ({push_ok, pop_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q; // both or neither
            endcase
        end
    end

    assign q_valid_o = (count_q != '0);
    assign q_pkt_o   = mem_q[rd_ptr_q[fetch_pkg::IDX_W-1:0]];

    // only real pops hand a credit back since fetch refills its count on redirect
    assign credit_return_o = pop_ok;

    // fetch credit accounting must keep the queue from overflowing
    no_push_full_a: assert property (
        @(posedge clk_i) disable iff (reset_i)
        push_ok |-> count_q != fetch_pkg::DEPTH_CNT
    ) else $error("push into full instruction queue");

    // decode only pops a visible head
    no_pop_empty_a: assert property (
        @(posedge clk_i) disable iff (reset_i)
        pop_i |-> count_q != '0
    ) else $error("pop from empty instruction queue");

endmodule

/* tb/tb_fetch_top.sv */
`timescale 1ns/100ps

module tb_fetch_top;

    localparam int CLK_PERIOD   = 8;     // ns
    localparam int RESET_CYCLES = 8;
    localparam int RUN_CYCLES   = 2000;  // stimulus cycles after reset
    localparam int WATCHDOG_NS  = 2 * (RESET_CYCLES + RUN_CYCLES + 16) * CLK_PERIOD;
    localparam int MIN_DECODED  = 200;   // floor for a healthy run

    logic             clk_i;
    logic             reset_i;
    logic             halt_i;
    logic             stall_i;
    fetch_pkg::word_t imem_data_i = '0;
    fetch_pkg::word_t imem_addr_o;
    logic             dec_valid_o;
    fetch_pkg::word_t dec_pc_o;
    fetch_pkg::word_t dec_ir_o;
    logic [4:0]       dec_rd_o;
    fetch_pkg::word_t dec_imm_o;

    logic [31:0]      lfsr_q;          // stimulus generator state
    int               burst_left;      // forced stall cycles still to go

    fetch_pkg::word_t exp_pc;          // next pc in program order
    int               hist_n;          // checked cycles since reset
    logic             stall_d;         // previous cycle's inputs
    logic             halt_d;
    fetch_pkg::word_t addr_d;          // imem_addr_o one cycle back
    fetch_pkg::word_t addr_dd;         // and two cycles back
    int               stall_run;       // unhalted stall cycles in the current run
    int               dec_count  = 0;
    int               jal_count  = 0;
    int               full_holds = 0;  // queue-full hold checks hit

    fetch_top dut (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .halt_i      (halt_i),
        .stall_i     (stall_i),
        .imem_data_i (imem_data_i),
        .imem_addr_o (imem_addr_o),
        .dec_valid_o (dec_valid_o),
        .dec_pc_o    (dec_pc_o),
        .dec_ir_o    (dec_ir_o),
        .dec_rd_o    (dec_rd_o),
        .dec_imm_o   (dec_imm_o)
    );

    // program layout, every seventh word is a jump
    function automatic logic jal_at(input fetch_pkg::word_t a);
        return ((a >> 2) % 7) == 6;
    endfunction

    function automatic fetch_pkg::word_t jal_offset(input fetch_pkg::word_t a);
        return a[5] ? 32'hffff_fff0 : 32'd8; // back 16 or forward 8
    endfunction

    // instruction word stored at address a
    function automatic fetch_pkg::word_t mem_word(input fetch_pkg::word_t a);
        fetch_pkg::word_t off;
        fetch_pkg::word_t ir;
        off = jal_offset(a);
        if (jal_at(a))
            ir = {off[20], off[10:1], off[11], off[19:12], 5'd0, fetch_pkg::OPC_JAL};
        else
            ir = {a[13:2], 5'd0, 3'b000, a[6:2], fetch_pkg::OPC_OP_IMM}; // addi rd, x0, imm
        return ir;
    endfunction

    function automatic logic [4:0] exp_rd(input fetch_pkg::word_t a);
        return jal_at(a) ? 5'd0 : a[6:2];
    endfunction

    function automatic fetch_pkg::word_t exp_imm(input fetch_pkg::word_t a);
        return jal_at(a) ? jal_offset(a) : {{20{a[13]}}, a[13:2]};
    endfunction

    // galois lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    task automatic draw_bits(input int n, output logic [7:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            bits   = {bits[6:0], lfsr_q[0]};
        end
    endtask

    task automatic end_in_failure();
        $display("Test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic value_mismatch(input string name, input fetch_pkg::word_t exp,
                                  input fetch_pkg::word_t act);
        $display("Mismatch at %0t: %s expected %h, actual %h", $time, name, exp, act);
        end_in_failure();
    endtask

    task automatic plain_error(input string why);
        $display("Error at %0t: %s", $time, why);
        end_in_failure();
    endtask

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // synchronous read memory
    always @(posedge clk_i) begin
        imem_data_i <= mem_word(imem_addr_o);
    end

    // checker runs mid-cycle, outputs settled
    always @(negedge clk_i) begin
        if (reset_i) begin
            assert (dec_valid_o === 1'b0)
                else value_mismatch("dec_valid_o", 32'd0, {31'd0, dec_valid_o});
            exp_pc    = fetch_pkg::RESET_PC; // first result must come from here
            hist_n    = 0;
            stall_run = 0;
        end else begin
            if (dec_valid_o) begin
                assert (dec_pc_o === exp_pc) else value_mismatch("dec_pc_o", exp_pc, dec_pc_o);
                assert (dec_ir_o === mem_word(dec_pc_o))
                    else value_mismatch("dec_ir_o", mem_word(dec_pc_o), dec_ir_o);
                assert (dec_rd_o === exp_rd(dec_pc_o))
                    else value_mismatch("dec_rd_o", {27'd0, exp_rd(dec_pc_o)}, {27'd0, dec_rd_o});
                assert (dec_imm_o === exp_imm(dec_pc_o))
                    else value_mismatch("dec_imm_o", exp_imm(dec_pc_o), dec_imm_o);
                exp_pc = dec_pc_o + (jal_at(dec_pc_o) ? jal_offset(dec_pc_o) : 32'd4);
                dec_count++;
                if (jal_at(dec_pc_o))
                    jal_count++;
            end
            // stalled cycle pops nothing
            if (hist_n >= 1 && stall_d)
                assert (dec_valid_o === 1'b0)
                    else value_mismatch("dec_valid_o", 32'd0, {31'd0, dec_valid_o});
            // halt holds the address unless that cycle redirected,
            // which shows up now as a decoded jal
            if (hist_n >= 2 && halt_d && !(dec_valid_o && dec_ir_o[6:0] == fetch_pkg::OPC_JAL))
                assert (addr_d === addr_dd) else value_mismatch("imem_addr_o", addr_dd, addr_d);
            // every credit spent during the stall run, fetch must sit still
            if (stall_i && stall_run >= fetch_pkg::QUEUE_DEPTH) begin
                assert (imem_addr_o === addr_d)
                    else value_mismatch("imem_addr_o", addr_d, imem_addr_o);
                full_holds++;
            end
            if (!stall_i)
                stall_run = 0;
            else if (!halt_i)
                stall_run++;     // one credit gone per unhalted cycle
            stall_d = stall_i;
            halt_d  = halt_i;
            addr_dd = addr_d;
            addr_d  = imem_addr_o;
            hist_n++;
        end
    end

    initial begin
        logic [7:0] r;
        reset_i    = 1'b1;
        halt_i     = 1'b0;
        stall_i    = 1'b0;
        lfsr_q     = 32'hec14;
        burst_left = 0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        reset_i <= 1'b0;
        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            if (burst_left > 0) begin
                stall_i    <= 1'b1;  // long run to fill the queue
                burst_left--;
            end else begin
                draw_bits(6, r);
                if (r[5:0] == 6'd0) begin
                    draw_bits(3, r);
                    burst_left = 8 + r[2:0];
                    stall_i    <= 1'b1;
                end else begin
                    draw_bits(2, r);
                    stall_i <= (r[1:0] == 2'b00);
                end
            end
            draw_bits(3, r);
            halt_i <= (r[2:0] == 3'b000); // roughly one in eight
            @(posedge clk_i);
        end
        stall_i <= 1'b0;
        halt_i  <= 1'b0;
        repeat (4) @(posedge clk_i);      // drain last results into the checker
        if (dec_count < MIN_DECODED || jal_count == 0 || full_holds == 0) begin
            plain_error($sformatf("too little activity: %0d decoded, %0d jumps, %0d full holds",
                                  dec_count, jal_count, full_holds));
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        plain_error("watchdog expired before the run finished");
    end

endmodule
